/* rtl/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// first fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// jumping here stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// architectural register file size
`define MIPS_NUM_REGS 32

// return address target of jal and the linking branches
`define MIPS_LINK_REG 5'd31

`endif

/* rtl/mips_pkg.sv */
`include "mips_consts.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll   = 6'h00,
        fn_srl   = 6'h02,
        fn_sra   = 6'h03,
        fn_jr    = 6'h08,
        fn_jalr  = 6'h09,
        fn_mfhi  = 6'h10,
        fn_mflo  = 6'h12,
        fn_mult  = 6'h18,
        fn_multu = 6'h19,
        fn_addu  = 6'h21,
        fn_subu  = 6'h23,
        fn_and   = 6'h24,
        fn_or    = 6'h25,
        fn_xor   = 6'h26,
        fn_slt   = 6'h2a,
        fn_sltu  = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
        alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic {
        phase_fetch   = 1'b0,
        phase_execute = 1'b1
    } phase_e;

    // source of the register write-back value
    typedef enum logic [2:0] {
        wb_alu, wb_mem, wb_hi, wb_lo, wb_link
    } wb_sel_e;

    typedef enum logic [1:0] {
        br_eq, br_ne, br_ltz, br_gez
    } branch_kind_e;

    typedef struct packed {
        alu_op_e                           alu_op;
        logic                              use_imm;
        logic                              imm_zero_ext;
        logic                              reg_write;
        logic [$clog2(`MIPS_NUM_REGS)-1:0] dest;
        wb_sel_e                           wb_sel;
        logic                              mem_read;
        logic                              mem_write;
        logic                              branch;
        branch_kind_e                      branch_kind;
        logic                              jump_imm;
        logic                              jump_reg;
        logic                              muldiv_write;
        logic                              mul_signed;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] mem_addr;
        logic        take_branch;
    } exec_t;

endpackage

/* rtl/mips_decoder.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_decoder (
    input  logic [31:0]     instr,
    output mips_pkg::ctrl_t ctrl
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    logic [4:0]        rt;
    logic [4:0]        rd;

    assign opcode = mips_pkg::opcode_e'(instr[31:26]);
    assign funct  = mips_pkg::funct_e'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        // anything not matched below behaves as a nop
        ctrl.alu_op       = mips_pkg::alu_add;
        ctrl.use_imm      = 1'b0;
        ctrl.imm_zero_ext = 1'b0;
        ctrl.reg_write    = 1'b0;
        ctrl.dest         = rt;
        ctrl.wb_sel       = mips_pkg::wb_alu;
        ctrl.mem_read     = 1'b0;
        ctrl.mem_write    = 1'b0;
        ctrl.branch       = 1'b0;
        ctrl.branch_kind  = mips_pkg::br_eq;
        ctrl.jump_imm     = 1'b0;
        ctrl.jump_reg     = 1'b0;
        ctrl.muldiv_write = 1'b0;
        ctrl.mul_signed   = 1'b0;

        case (opcode)
            mips_pkg::op_special: begin
                ctrl.dest      = rd;
                ctrl.reg_write = 1'b1;
                case (funct)
                    mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
                    mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
                    mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
                    mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
                    mips_pkg::fn_sra:  ctrl.alu_op = mips_pkg::alu_sra;
                    mips_pkg::fn_mfhi: ctrl.wb_sel = mips_pkg::wb_hi;
                    mips_pkg::fn_mflo: ctrl.wb_sel = mips_pkg::wb_lo;
                    mips_pkg::fn_jr: begin
                        ctrl.jump_reg  = 1'b1;
                        ctrl.reg_write = 1'b0;
                    end
                    mips_pkg::fn_jalr: begin
                        ctrl.jump_reg = 1'b1;
                        ctrl.wb_sel   = mips_pkg::wb_link;
                    end
                    mips_pkg::fn_mult, mips_pkg::fn_multu: begin
                        ctrl.reg_write    = 1'b0;
                        ctrl.muldiv_write = 1'b1;
                        ctrl.mul_signed   = (funct == mips_pkg::fn_mult);
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::op_regimm: begin
                // only bltz, bgez, bltzal and bgezal
                if (rt[3:1] == 3'b000) begin
                    ctrl.branch      = 1'b1;
                    ctrl.branch_kind = rt[0] ? mips_pkg::br_gez : mips_pkg::br_ltz;
                    // linking forms write r31 whether taken or not
                    if (rt[4]) begin
                        ctrl.reg_write = 1'b1;
                        ctrl.dest      = `MIPS_LINK_REG;
                        ctrl.wb_sel    = mips_pkg::wb_link;
                    end
                end
            end
            mips_pkg::op_j: ctrl.jump_imm = 1'b1;
            mips_pkg::op_jal: begin
                ctrl.jump_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = `MIPS_LINK_REG;
                ctrl.wb_sel    = mips_pkg::wb_link;
            end
            mips_pkg::op_beq: begin
                ctrl.branch      = 1'b1;
                ctrl.branch_kind = mips_pkg::br_eq;
            end
            mips_pkg::op_bne: begin
                ctrl.branch      = 1'b1;
                ctrl.branch_kind = mips_pkg::br_ne;
            end
            mips_pkg::op_addiu, mips_pkg::op_slti: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = (opcode == mips_pkg::op_slti) ? mips_pkg::alu_slt
                                                                : mips_pkg::alu_add;
            end
            mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: begin
                ctrl.reg_write    = 1'b1;
                ctrl.use_imm      = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                case (opcode)
                    mips_pkg::op_andi: ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::op_ori:  ctrl.alu_op = mips_pkg::alu_or;
                    default:           ctrl.alu_op = mips_pkg::alu_xor;
                endcase
            end
            mips_pkg::op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = mips_pkg::alu_lui;
            end
            mips_pkg::op_lw: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_sel    = mips_pkg::wb_mem;
            end
            mips_pkg::op_sw: ctrl.mem_write = 1'b1;
            default: ;
        endcase
    end

endmodule

/* rtl/mips_regfile.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        write_en,
    input  logic [4:0]  read_index_a,
    input  logic [4:0]  read_index_b,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    logic [31:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (write_en && write_index != 5'd0) begin
            regs[write_index] <= write_data;
        end
    end

    // r0 is never written, so it reads as zero
    assign read_data_a = regs[read_index_a];
    assign read_data_b = regs[read_index_b];

    // v0 is r2
    assign register_v0 = regs[2];

endmodule

/* rtl/mips_execute.sv */
`timescale 1ns/1ps

module mips_execute (
    input  logic            clk,
    input  logic            reset,
    input  logic            clk_enable,
    input  logic            exec_phase,
    input  logic            active,
    input  mips_pkg::ctrl_t ctrl,
    input  logic [31:0]     op_a,
    input  logic [31:0]     op_b,
    input  logic [31:0]     instr,
    output mips_pkg::exec_t result,
    output logic [31:0]     hi_out,
    output logic [31:0]     lo_out
);

    logic [31:0]        imm_sext;
    logic [31:0]        imm_ext;
    logic [31:0]        operand_b;
    logic [4:0]         shamt;
    logic [31:0]        alu_out;
    logic               branch_cond;
    logic signed [63:0] product_signed;
    logic [63:0]        product_unsigned;
    logic [63:0]        product;

    assign imm_sext  = {{16{instr[15]}}, instr[15:0]};
    assign imm_ext   = ctrl.imm_zero_ext ? {16'd0, instr[15:0]} : imm_sext;
    assign operand_b = ctrl.use_imm ? imm_ext : op_b;
    assign shamt     = instr[10:6];

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::alu_add:  alu_out = op_a + operand_b;
            mips_pkg::alu_sub:  alu_out = op_a - operand_b;
            mips_pkg::alu_and:  alu_out = op_a & operand_b;
            mips_pkg::alu_or:   alu_out = op_a | operand_b;
            mips_pkg::alu_xor:  alu_out = op_a ^ operand_b;
            mips_pkg::alu_slt:  alu_out = {31'd0, $signed(op_a) < $signed(operand_b)};
            mips_pkg::alu_sltu: alu_out = {31'd0, op_a < operand_b};
            // shifts always act on rt
            mips_pkg::alu_sll:  alu_out = op_b << shamt;
            mips_pkg::alu_srl:  alu_out = op_b >> shamt;
            mips_pkg::alu_sra:  alu_out = $unsigned($signed(op_b) >>> shamt);
            mips_pkg::alu_lui:  alu_out = {instr[15:0], 16'd0};
            default:            alu_out = op_a + operand_b;
        endcase
    end

    always_comb begin
        case (ctrl.branch_kind)
            mips_pkg::br_eq:  branch_cond = (op_a == op_b);
            mips_pkg::br_ne:  branch_cond = (op_a != op_b);
            mips_pkg::br_ltz: branch_cond = op_a[31];
            default:          branch_cond = !op_a[31];
        endcase
    end

    assign result.result      = alu_out;
    assign result.mem_addr    = op_a + imm_sext;
    assign result.take_branch = ctrl.branch && branch_cond;

    // full 64-bit products for mult and multu
    assign product_signed   = $signed(op_a) * $signed(op_b);
    assign product_unsigned = {32'd0, op_a} * {32'd0, op_b};
    assign product = ctrl.mul_signed ? $unsigned(product_signed) : product_unsigned;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_out <= 32'd0;
            lo_out <= 32'd0;
        end else if (clk_enable && exec_phase && active && ctrl.muldiv_write) begin
            hi_out <= product[63:32];
            lo_out <= product[31:0];
        end
    end

endmodule

/* rtl/mips_pc_unit.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_pc_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             clk_enable,
    input  mips_pkg::ctrl_t  ctrl,
    input  logic             take_branch,
    input  logic [31:0]      jump_target_reg,
    input  logic [31:0]      instr,
    output logic [31:0]      pc,
    output logic [31:0]      delay_slot,
    output mips_pkg::phase_e phase,
    output logic             active
);

    logic [31:0] branch_offset;
    logic [31:0] next_addr;

    assign branch_offset = {{14{instr[15]}}, instr[15:0], 2'b00};

    // address that follows the delay slot
    always_comb begin
        if (take_branch) begin
            next_addr = delay_slot + branch_offset;
        end else if (ctrl.jump_imm) begin
            next_addr = {delay_slot[31:28], instr[25:0], 2'b00};
        end else if (ctrl.jump_reg) begin
            next_addr = jump_target_reg;
        end else begin
            // sequential, one word past the incoming pc
            next_addr = delay_slot + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= `MIPS_RESET_VECTOR;
            delay_slot <= `MIPS_RESET_VECTOR + 32'd4;
            phase      <= mips_pkg::phase_fetch;
        end else if (clk_enable && active) begin
            if (phase == mips_pkg::phase_fetch) begin
                phase <= mips_pkg::phase_execute;
            end else begin
                phase      <= mips_pkg::phase_fetch;
                pc         <= delay_slot;
                delay_slot <= next_addr;
            end
        end
    end

    // core stops once it reaches the halt address
    assign active = (pc != `MIPS_HALT_ADDR);

endmodule

/* rtl/mips_cpu_harvard.sv */
`timescale 1ns/1ps

module mips_cpu_harvard (
    input  logic        clk,
    input  logic        reset,
    output logic        active,
    output logic [31:0] register_v0,

    input  logic        clk_enable,

    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    mips_pkg::ctrl_t  ctrl;
    mips_pkg::exec_t  exec;
    mips_pkg::phase_e phase;
    logic             exec_phase;
    logic [31:0]      read_data_a;
    logic [31:0]      read_data_b;
    logic [31:0]      hi_out;
    logic [31:0]      lo_out;
    logic [31:0]      pc;
    logic [31:0]      delay_slot;
    logic [31:0]      write_data;
    logic             write_en;

    assign exec_phase = (phase == mips_pkg::phase_execute);

    // state changes only on an enabled execute cycle of a running core
    assign write_en   = clk_enable && active && exec_phase && ctrl.reg_write;
    assign data_write = active && exec_phase && ctrl.mem_write;
    assign data_read  = active && exec_phase && ctrl.mem_read;

    assign instr_address  = pc;
    assign data_address   = exec.mem_addr;
    assign data_writedata = read_data_b;

    always_comb begin
        case (ctrl.wb_sel)
            mips_pkg::wb_mem:  write_data = data_readdata;
            mips_pkg::wb_hi:   write_data = hi_out;
            mips_pkg::wb_lo:   write_data = lo_out;
            // return past the delay slot
            mips_pkg::wb_link: write_data = delay_slot + 32'd4;
            default:           write_data = exec.result;
        endcase
    end

    mips_decoder u_decoder (
        .instr (instr_readdata),
        .ctrl  (ctrl)
    );

    mips_regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .write_en     (write_en),
        .read_index_a (instr_readdata[25:21]),
        .read_index_b (instr_readdata[20:16]),
        .write_index  (ctrl.dest),
        .write_data   (write_data),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b),
        .register_v0  (register_v0)
    );

    mips_execute u_execute (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .exec_phase (exec_phase),
        .active     (active),
        .ctrl       (ctrl),
        .op_a       (read_data_a),
        .op_b       (read_data_b),
        .instr      (instr_readdata),
        .result     (exec),
        .hi_out     (hi_out),
        .lo_out     (lo_out)
    );

    mips_pc_unit u_pc_unit (
        .clk             (clk),
        .reset           (reset),
        .clk_enable      (clk_enable),
        .ctrl            (ctrl),
        .take_branch     (exec.take_branch),
        .jump_target_reg (read_data_a),
        .instr           (instr_readdata),
        .pc              (pc),
        .delay_slot      (delay_slot),
        .phase           (phase),
        .active          (active)
    );

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 4 ns period
    always #2 clk = ~clk;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* test/tb_mips_cpu.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module tb_mips_cpu;

    localparam int VEC_DEPTH       = 256;
    localparam int ROM_DEPTH       = 128;
    localparam int RAM_DEPTH       = 1024;
    localparam int STALL_STRETCHES = 6;
    localparam int STALL_MAX_LOW   = 4;
    localparam int HALT_WATCH      = 20;

    // sw r0, 0(r0) fetched from anywhere outside the image
    localparam logic [31:0] OFF_IMAGE_WORD = 32'hAC00_0000;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] vectors [VEC_DEPTH];
    logic [31:0] rom [ROM_DEPTH];
    logic [31:0] ram [RAM_DEPTH];
    logic [31:0] rom_index;

    int          n_instr;
    int          n_stores;
    int          store_base;
    int          store_idx = 0;
    int          n_reads = 0;
    int          cycle_limit = 1000;
    int          cycles = 0;
    logic [31:0] expected_v0;

    logic [31:0] last_instr_address;
    logic [31:0] last_v0;
    logic        last_data_write;
    logic        last_enable = 1'b1;
    logic        checking = 1'b0;

    clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    mips_cpu_harvard dut (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error at %0t ns: %s expected %h, got %h", $time, sig, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "value mismatch on %s", sig);
    endtask

    task automatic stop_with(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    // instruction ROM, image starts at the reset vector
    assign rom_index      = (instr_address - `MIPS_RESET_VECTOR) >> 2;
    assign instr_readdata = (rom_index < ROM_DEPTH) ? rom[rom_index[6:0]] : OFF_IMAGE_WORD;

    // data RAM, word addressed
    assign data_readdata = ram[data_address[11:2]];

    always @(posedge clk) begin
        if (!reset && clk_enable && data_write) begin
            ram[data_address[11:2]] <= data_writedata;
        end
    end

    // every committed store against the expected list
    always @(negedge clk) begin
        if (!reset && clk_enable && data_write) begin
            assert (store_idx < n_stores)
            else stop_with("the core stored more words than expected");
            assert (data_address == vectors[store_base + 2 * store_idx])
            else report_mismatch("data_address", vectors[store_base + 2 * store_idx],
                                 data_address);
            assert (data_writedata == vectors[store_base + 2 * store_idx + 1])
            else report_mismatch("data_writedata", vectors[store_base + 2 * store_idx + 1],
                                 data_writedata);
            store_idx <= store_idx + 1;
        end
    end

    // data reads belong to lw only
    always @(negedge clk) begin
        if (!reset && data_read) begin
            assert (instr_readdata[31:26] == 6'h23)
            else report_mismatch("data_read opcode", 32'h23, {26'd0, instr_readdata[31:26]});
            if (clk_enable) begin
                n_reads <= n_reads + 1;
            end
        end
    end

    // a stalled edge must leave the visible state alone
    always @(negedge clk) begin
        if (checking && !last_enable) begin
            assert (instr_address == last_instr_address)
            else report_mismatch("instr_address", last_instr_address, instr_address);
            assert (data_write == last_data_write)
            else report_mismatch("data_write", {31'd0, last_data_write}, {31'd0, data_write});
            assert (register_v0 == last_v0)
            else report_mismatch("register_v0", last_v0, register_v0);
        end
        last_instr_address <= instr_address;
        last_data_write    <= data_write;
        last_v0            <= register_v0;
        last_enable        <= clk_enable;
        checking           <= !reset;
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycles <= cycles + 1;
            if (cycles >= cycle_limit) begin
                stop_with($sformatf("timeout, core still active after %0d cycles", cycles));
            end
        end
    end

    initial begin
        int low_len;
        int high_len;

        clk_enable = 1'b1;
        void'($urandom(32'h4c9c));
        for (int i = 0; i < VEC_DEPTH; i++) begin
            vectors[i] = 32'd0;
        end
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = 32'd0;
        end
        for (int i = 0; i < RAM_DEPTH; i++) begin
            ram[i] = 32'd0;
        end
        $readmemh("test/mips_vectors.hex", vectors);

        // image length, image, store count, store pairs, final v0
        n_instr = int'(vectors[0]);
        for (int i = 0; i < n_instr; i++) begin
            rom[i] = vectors[1 + i];
        end
        n_stores    = int'(vectors[1 + n_instr]);
        store_base  = 2 + n_instr;
        expected_v0 = vectors[store_base + 2 * n_stores];
        cycle_limit = 2 * n_instr * 4 + STALL_STRETCHES * STALL_MAX_LOW;

        @(negedge reset);
        @(negedge clk);
        assert (active) else stop_with("active is low right after reset");
        assert (!data_write)
        else report_mismatch("data_write", 32'd0, {31'd0, data_write});
        assert (!data_read)
        else report_mismatch("data_read", 32'd0, {31'd0, data_read});
        assert (instr_address == `MIPS_RESET_VECTOR)
        else report_mismatch("instr_address", `MIPS_RESET_VECTOR, instr_address);
        @(negedge clk);
        assert (instr_address == `MIPS_RESET_VECTOR)
        else report_mismatch("instr_address", `MIPS_RESET_VECTOR, instr_address);
        @(negedge clk);
        assert (instr_address == `MIPS_RESET_VECTOR + 32'd4)
        else report_mismatch("instr_address", `MIPS_RESET_VECTOR + 32'd4, instr_address);

        // stall window with random stretches of clk_enable low
        repeat (8) @(posedge clk);
        for (int s = 0; s < STALL_STRETCHES; s++) begin
            low_len  = int'($urandom % STALL_MAX_LOW) + 1;
            high_len = int'($urandom % 4) + 1;
            #1 clk_enable = 1'b0;
            repeat (low_len) @(posedge clk);
            #1 clk_enable = 1'b1;
            repeat (high_len) @(posedge clk);
        end

        while (active) begin
            @(negedge clk);
        end
        repeat (HALT_WATCH) begin
            @(negedge clk);
            assert (!data_write) else stop_with("data_write asserted after the core halted");
        end

        assert (store_idx == n_stores)
        else report_mismatch("store count", n_stores, store_idx);
        assert (n_reads > 0) else stop_with("the core never asserted data_read");
        assert (register_v0 == expected_v0)
        else report_mismatch("register_v0", expected_v0, register_v0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* mips_cpu_harvard.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_decoder.sv
rtl/mips_regfile.sv
rtl/mips_execute.sv
rtl/mips_pc_unit.sv
rtl/mips_cpu_harvard.sv
test/clock_gen.sv
test/tb_mips_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mips_cpu --Mdir obj_dir \
    -f mips_cpu_harvard.f &&
./obj_dir/Vtb_mips_cpu || { echo "simulation did not pass"; exit 1; }

/* test/mips_vectors.hex */
// image length, then one instruction word per line from the reset vector
// then the store count, address and data pairs, and the expected final v0
0000002F
34100100
2408FFFB
3C091234
35295678
01095021
AE0A0000
00085843
01695826
AE0B0004
0128602B
00086F02
01AC6023
AE0C0008
8E0E0000
AE0E000C
01090018
00007810
AE0F0010
00007812
AE0F0014
01090019
00007810
AE0F0018
11090002
AE0C001C
AE090020
15090002
AE080024
AE000028
05100002
AE1F002C
AE000030
05010001
AE0C0030
3C11BFC0
363100A0
02201009
AE020034
AE000038
AE00003C
0FF0002C
AE1F0038
0000F821
AE02003C
24420004
03E00008
AE020040
// stores, address then data
00000011
00000100 12345673
00000104 EDCBA985
00000108 0000000E
0000010C 12345673
00000110 FFFFFFFF
00000114 A4FA4FA8
00000118 12345677
0000011C 0000000E
00000120 12345678
00000124 FFFFFFFB
0000012C BFC0007C
00000130 0000000E
00000134 BFC00098
00000138 BFC000A8
00000140 BFC0009C
0000013C BFC0009C
00000140 BFC000A0
// final v0
BFC000A0
